// File: testbench/arrayHeapTb.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Array heap testbench
// Replays requests from the pattern file and checks every response
//----------------------------

module arrayHeapTb;
  import heapPkg::*;

  localparam int addressBits   = 2;
  localparam int indexBits     = 3;
  localparam int dataBits      = 12;
  localparam int fields        = 6;    // Words per pattern line
  localparam int maxPatterns   = 128;
  localparam int timeoutCycles = 10;
  localparam int resetTimeout  = 20;

  logic                   clock;
  logic                   resetN;
  logic                   reqValid;
  heapOp_e                reqOp;
  logic [addressBits-1:0] reqArray;
  logic [indexBits-1:0]   reqIndex;
  logic [dataBits-1:0]    reqData;
  logic                   respValid;
  logic [dataBits-1:0]    respData;
  heapErr_e               respError;

  logic [15:0] patterns [fields * maxPatterns];
  int          patternCount;
  int          dataErrors;
  int          codeErrors;
  int          timeouts;
  int          setupErrors;

  clockGen #(.periodNs(8), .resetCycles(2)) clocks (
    .clock  (clock),
    .resetN (resetN)
  );

  arrayHeap #(
    .addressBits (addressBits),
    .indexBits   (indexBits),
    .dataBits    (dataBits)
  ) dut (
    .clock     (clock),
    .resetN    (resetN),
    .reqValid  (reqValid),
    .reqOp     (reqOp),
    .reqArray  (reqArray),
    .reqIndex  (reqIndex),
    .reqData   (reqData),
    .respValid (respValid),
    .respData  (respData),
    .respError (respError)
  );

  //----------------------------
  // One request and its response
  //----------------------------
  task automatic applyPattern(input int number);
    int                  base;
    int                  waited;
    logic [dataBits-1:0] expData;
    heapErr_e            expError;
    base     = number * fields;
    expData  = patterns[base + 4][dataBits-1:0];
    expError = heapErr_e'(patterns[base + 5][2:0]);
    @(posedge clock);
    reqValid <= 1'b1;
    reqOp    <= heapOp_e'(patterns[base][4:0]);
    reqArray <= patterns[base + 1][addressBits-1:0];
    reqIndex <= patterns[base + 2][indexBits-1:0];
    reqData  <= patterns[base + 3][dataBits-1:0];
    @(posedge clock);                             // Request taken here
    reqValid <= 1'b0;
    waited = 0;
    @(negedge clock);
    while (!respValid && waited < timeoutCycles) begin
      @(negedge clock);
      waited++;
    end
    assert (respValid) else begin
      timeouts++;
      $display("No response to pattern %0d within %0d cycles", number, timeoutCycles);
    end
    if (respValid) begin
      assert (respData === expData) else begin
        dataErrors++;
        $display("Mismatch respData in pattern %0d: got %h, expected %h",
                 number, respData, expData);
      end
      assert (respError === expError) else begin
        codeErrors++;
        $display("Mismatch respError in pattern %0d: got %h, expected %h",
                 number, respError, expError);
      end
    end
  endtask

  initial begin
    int waited;
    reqValid     = 1'b0;
    reqOp        = opClear;
    reqArray     = '0;
    reqIndex     = '0;
    reqData      = '0;
    dataErrors   = 0;
    codeErrors   = 0;
    timeouts     = 0;
    setupErrors  = 0;
    patternCount = 0;
    $readmemh("testbench/heapPatterns.txt", patterns);
    while (patternCount < maxPatterns && !$isunknown(patterns[patternCount * fields])) begin
      patternCount++;
    end
    assert (patternCount > 0) else begin
      setupErrors++;
      $display("No patterns could be read from the pattern file");
    end
    waited = 0;
    while (resetN !== 1'b1 && waited < resetTimeout) begin
      @(posedge clock);
      waited++;
    end
    assert (resetN === 1'b1) else begin
      setupErrors++;
      $display("Reset was never released");
    end
    if (resetN === 1'b1) begin
      for (int i = 0; i < patternCount; i++) begin
        applyPattern(i);
      end
    end
    $display("Errors over %0d patterns: respData %0d, respError %0d, timeouts %0d, setup %0d",
             patternCount, dataErrors, codeErrors, timeouts, setupErrors);
    if (dataErrors + codeErrors + timeouts + setupErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/arrayHeap_assert.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Array heap protocol checks
// Response timing and error data rules
//----------------------------

module arrayHeapAssert #(
  parameter int dataBits = 12
) (
  input wire                     clock,
  input wire                     resetN,
  input wire                     reqValid,
  input wire                     respValid,
  input wire [dataBits-1:0]      respData,
  input wire  heapPkg::heapErr_e respError
);
  import heapPkg::*;

  // One response per request, one cycle later
  responseFollowsRequest: assert property (
    @(posedge clock) disable iff (!resetN) respValid == $past(reqValid)
  ) else $error("respValid did not follow reqValid by one cycle");

  quietDuringReset: assert property (
    @(posedge clock) !resetN |-> !respValid
  ) else $error("respValid high during reset");

  // Failed requests carry no data
  zeroDataOnError: assert property (
    @(posedge clock) disable iff (!resetN) (respError != errNone) |-> (respData == '0)
  ) else $error("respData not zero with an error code");

endmodule

bind arrayHeap arrayHeapAssert #(.dataBits(dataBits)) protocolChecks (
  .clock     (clock),
  .resetN    (resetN),
  .reqValid  (reqValid),
  .respValid (respValid),
  .respData  (respData),
  .respError (respError)
);

`default_nettype wire

// File: testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Testbench clock and reset
//----------------------------

module clockGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 2
) (
  output logic clock,
  output logic resetN
);

  initial begin
    clock  = 1'b0;
    resetN = 1'b0;                                // Held low from time zero
    repeat (resetCycles) @(posedge clock);
    resetN <= 1'b1;
  end

  always #(periodNs / 2) clock = ~clock;

endmodule

`default_nettype wire

// File: testbench/heapPatterns.txt
// Columns: opcode array index data expectedData expectedError, all hex
// Opcode and error numbers follow the heapPkg enums
// Never allocated
04 0 0 000 000 1
// Allocation order, out of memory, reuse
01 0 0 000 000 0
01 0 0 000 001 0
01 0 0 000 002 0
01 0 0 000 003 0
01 0 0 000 000 6
02 1 0 000 000 0
01 0 0 000 001 0
// Write grows the size
03 1 2 5a5 5a5 0
05 1 0 000 003 0
04 1 2 000 5a5 0
04 1 3 000 000 3
// Push to full, pop to empty
06 2 0 101 101 0
06 2 0 202 202 0
06 2 0 303 303 0
06 2 0 404 404 0
06 2 0 505 505 0
06 2 0 606 606 0
06 2 0 707 707 0
06 2 0 808 808 0
06 2 0 909 000 4
07 2 0 000 808 0
07 2 0 000 707 0
07 2 0 000 606 0
07 2 0 000 505 0
07 2 0 000 404 0
07 2 0 000 303 0
07 2 0 000 202 0
07 2 0 000 101 0
07 2 0 000 000 5
// Read-modify-write on one element
03 0 0 ff0 ff0 0
08 0 0 020 010 0
09 0 0 005 010 0
04 0 0 000 015 0
0a 0 0 020 ff5 0
0b 0 0 0f5 ff5 0
0c 0 0 002 c00 0
0d 0 0 003 180 0
0e 0 0 000 e7f 0
0f 0 0 100 f7f 0
10 0 0 0ff f80 0
11 0 0 8c3 880 0
04 0 0 000 880 0
08 0 5 001 000 3
// Freed arrays, double free, clear
02 3 0 000 000 0
04 3 0 000 000 2
02 3 0 000 000 2
00 0 0 000 000 0
04 0 0 000 000 1
01 0 0 000 000 0
05 2 0 000 000 1

// File: verilog/arrayDirectory.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Array directory
// Keeps live flags, array sizes and the stack of freed array numbers
//----------------------------

module arrayDirectory #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3
) (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire  [addressBits-1:0] lookupArray,     // Array of the current request
  output logic                   everAllocated,
  output logic                   live,
  output logic [indexBits:0]     arraySize,
  output logic [addressBits-1:0] allocArray,      // Array the next Alloc gets
  output logic                   allocAvailable,
  input  wire                    sizeWrite,
  input  wire  [indexBits:0]     sizeValue,
  input  wire                    allocStrobe,
  input  wire                    freeStrobe,
  input  wire                    clearStrobe
);
  import heapPkg::*;

  localparam int arrays    = depthOf(addressBits);
  localparam int countBits = addressBits + 1;
  localparam int sizeBits  = sizeWidth(indexBits);

  logic [countBits-1:0]   handedOut;              // Fresh blocks used so far
  logic [countBits-1:0]   freeTop;                // Entries on the free stack
  logic [countBits-1:0]   topSlot;
  logic [arrays-1:0]      liveFlags;
  logic                   stackEmpty;
  logic [sizeBits-1:0]    sizes     [arrays];
  logic [addressBits-1:0] freeStack [arrays];

  //----------------------------
  // Lookups
  //----------------------------
  assign stackEmpty    = (freeTop == '0);
  assign topSlot       = freeTop - 1'b1;
  assign everAllocated = ({1'b0, lookupArray} < handedOut);
  assign live          = liveFlags[lookupArray];
  assign arraySize     = sizes[lookupArray];

  // Reuse the last freed array first
  assign allocArray     = stackEmpty ? handedOut[addressBits-1:0]
                                     : freeStack[topSlot[addressBits-1:0]];
  assign allocAvailable = !stackEmpty || (handedOut < countBits'(arrays));

  //----------------------------
  // Allocation state
  //----------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      handedOut <= '0;
      freeTop   <= '0;
      liveFlags <= '0;
    end else if (clearStrobe) begin
      handedOut <= '0;                            // Whole heap back to empty
      freeTop   <= '0;
      liveFlags <= '0;
    end else if (allocStrobe) begin
      if (stackEmpty) begin
        handedOut <= handedOut + 1'b1;            // Take a fresh block
      end else begin
        freeTop <= topSlot;                       // Pop the free stack
      end
      liveFlags[allocArray] <= 1'b1;
    end else if (freeStrobe) begin
      freeTop                <= freeTop + 1'b1;
      liveFlags[lookupArray] <= 1'b0;
    end
  end

  // Array sizes and free stack entries
  always_ff @(posedge clock) begin
    if (allocStrobe) begin
      sizes[allocArray] <= '0;                    // New array starts empty
    end else if (sizeWrite) begin
      sizes[lookupArray] <= sizeValue;
    end
    if (freeStrobe) begin
      freeStack[freeTop[addressBits-1:0]] <= lookupArray;
    end
  end

endmodule

`default_nettype wire

// File: verilog/arrayHeap.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Array heap top level
// Ties the directory and the element store to the controller
//----------------------------

module arrayHeap #(
  parameter int addressBits = 2,   // Array number width
  parameter int indexBits   = 3,   // Element index width
  parameter int dataBits    = 12   // Element width
) (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire                    reqValid,
  input  wire  heapPkg::heapOp_e reqOp,
  input  wire  [addressBits-1:0] reqArray,
  input  wire  [indexBits-1:0]   reqIndex,
  input  wire  [dataBits-1:0]    reqData,
  output logic                   respValid,
  output logic [dataBits-1:0]    respData,
  output heapPkg::heapErr_e      respError
);

  logic                   everAllocated;
  logic                   live;
  logic [indexBits:0]     arraySize;
  logic [addressBits-1:0] allocArray;
  logic                   allocAvailable;
  logic [dataBits-1:0]    readData;
  logic [indexBits-1:0]   elementIndex;
  logic                   sizeWrite;
  logic [indexBits:0]     sizeValue;
  logic                   allocStrobe;
  logic                   freeStrobe;
  logic                   clearStrobe;
  logic                   writeStrobe;
  logic [indexBits-1:0]   writeIndex;
  logic [dataBits-1:0]    writeData;

  arrayDirectory #(
    .addressBits (addressBits),
    .indexBits   (indexBits)
  ) directory (
    .clock          (clock),
    .resetN         (resetN),
    .lookupArray    (reqArray),
    .everAllocated  (everAllocated),
    .live           (live),
    .arraySize      (arraySize),
    .allocArray     (allocArray),
    .allocAvailable (allocAvailable),
    .sizeWrite      (sizeWrite),
    .sizeValue      (sizeValue),
    .allocStrobe    (allocStrobe),
    .freeStrobe     (freeStrobe),
    .clearStrobe    (clearStrobe)
  );

  elementStore #(
    .addressBits (addressBits),
    .indexBits   (indexBits),
    .dataBits    (dataBits)
  ) store (
    .clock       (clock),
    .readArray   (reqArray),
    .readIndex   (elementIndex),
    .readData    (readData),
    .writeStrobe (writeStrobe),
    .writeArray  (reqArray),        // Writes stay in the requested array
    .writeIndex  (writeIndex),
    .writeData   (writeData)
  );

  heapController #(
    .addressBits (addressBits),
    .indexBits   (indexBits),
    .dataBits    (dataBits)
  ) controller (
    .clock          (clock),
    .resetN         (resetN),
    .reqValid       (reqValid),
    .reqOp          (reqOp),
    .reqArray       (reqArray),
    .reqIndex       (reqIndex),
    .reqData        (reqData),
    .everAllocated  (everAllocated),
    .live           (live),
    .arraySize      (arraySize),
    .allocArray     (allocArray),
    .allocAvailable (allocAvailable),
    .readData       (readData),
    .elementIndex   (elementIndex),
    .sizeWrite      (sizeWrite),
    .sizeValue      (sizeValue),
    .allocStrobe    (allocStrobe),
    .freeStrobe     (freeStrobe),
    .clearStrobe    (clearStrobe),
    .writeStrobe    (writeStrobe),
    .writeIndex     (writeIndex),
    .writeData      (writeData),
    .respValid      (respValid),
    .respData       (respData),
    .respError      (respError)
  );

endmodule

`default_nettype wire

// File: verilog/elementStore.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Element store
// Block memory with the contents of every array, one fixed block each
//----------------------------

module elementStore #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input  wire                    clock,
  input  wire  [addressBits-1:0] readArray,
  input  wire  [indexBits-1:0]   readIndex,
  output logic [dataBits-1:0]    readData,
  input  wire                    writeStrobe,
  input  wire  [addressBits-1:0] writeArray,
  input  wire  [indexBits-1:0]   writeIndex,
  input  wire  [dataBits-1:0]    writeData
);
  import heapPkg::*;

  localparam int wordBits = addressBits + indexBits;
  localparam int words    = depthOf(wordBits);

  logic [dataBits-1:0] memory [words];
  logic [wordBits-1:0] readAddress;
  logic [wordBits-1:0] writeAddress;

  // Array number picks the block, index the word within it
  assign readAddress  = {readArray, readIndex};
  assign writeAddress = {writeArray, writeIndex};

  assign readData = memory[readAddress];          // Same-cycle read

  always_ff @(posedge clock) begin
    if (writeStrobe) begin
      memory[writeAddress] <= writeData;
    end
  end

endmodule

`default_nettype wire

// File: verilog/heapController.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------
// Heap controller
// Checks each request, computes its result, fires the commit strobes
// and registers the response
//----------------------------

module heapController #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire                    reqValid,
  input  wire  heapPkg::heapOp_e reqOp,
  input  wire  [addressBits-1:0] reqArray,
  input  wire  [indexBits-1:0]   reqIndex,
  input  wire  [dataBits-1:0]    reqData,
  input  wire                    everAllocated,
  input  wire                    live,
  input  wire  [indexBits:0]     arraySize,
  input  wire  [addressBits-1:0] allocArray,
  input  wire                    allocAvailable,
  input  wire  [dataBits-1:0]    readData,
  output logic [indexBits-1:0]   elementIndex,
  output logic                   sizeWrite,
  output logic [indexBits:0]     sizeValue,
  output logic                   allocStrobe,
  output logic                   freeStrobe,
  output logic                   clearStrobe,
  output logic                   writeStrobe,
  output logic [indexBits-1:0]   writeIndex,
  output logic [dataBits-1:0]    writeData,
  output logic                   respValid,
  output logic [dataBits-1:0]    respData,
  output heapPkg::heapErr_e      respError
);
  import heapPkg::*;

  localparam int depth    = depthOf(indexBits);
  localparam int sizeBits = sizeWidth(indexBits);

  heapErr_e            arrayError;
  heapErr_e            errorCode;
  logic                arrayKnown;
  logic                inBounds;
  logic                commit;
  logic                storeValue;
  logic                changeSize;
  logic                doAlloc;
  logic                doFree;
  logic                doClear;
  logic [sizeBits-1:0] lastSize;
  logic [sizeBits-1:0] grownSize;
  logic [sizeBits-1:0] newSize;
  logic [dataBits-1:0] aluValue;
  logic [dataBits-1:0] result;

  // Array checks come first, then the operation's own check
  function automatic heapErr_e checkOp(input heapErr_e arrayErr, input logic fail,
                                       input heapErr_e failErr);
    if (arrayErr != errNone) begin
      return arrayErr;
    end
    return fail ? failErr : errNone;
  endfunction

  assign lastSize   = arraySize - 1'b1;
  assign grownSize  = arraySize + 1'b1;
  assign inBounds   = ({1'b0, reqIndex} < arraySize);
  assign arrayKnown = everAllocated;

  always_comb begin
    if (!arrayKnown)  arrayError = errNotAllocated;
    else if (!live)   arrayError = errFreed;
    else              arrayError = errNone;
  end

  // Push and pop work at the end of the array
  always_comb begin
    case (reqOp)
      opPush:  elementIndex = arraySize[indexBits-1:0];
      opPop:   elementIndex = lastSize[indexBits-1:0];
      default: elementIndex = reqIndex;
    endcase
  end

  //----------------------------
  // Element ALU
  //----------------------------
  always_comb begin
    case (reqOp)
      opAdd, opAddAfter: aluValue = readData + reqData;   // Wraps at dataBits
      opSub, opSubAfter: aluValue = readData - reqData;
      opShiftLeft:       aluValue = readData << reqData;
      opShiftRight:      aluValue = readData >> reqData;
      opNot:             aluValue = ~readData;
      opOr:              aluValue = readData | reqData;
      opXor:             aluValue = readData ^ reqData;
      opAnd:             aluValue = readData & reqData;
      default:           aluValue = reqData;               // Write and push store the data
    endcase
  end

  //----------------------------
  // Request decode
  //----------------------------
  always_comb begin
    errorCode  = errNone;
    result     = '0;
    storeValue = 1'b0;
    changeSize = 1'b0;
    newSize    = arraySize;
    doAlloc    = 1'b0;
    doFree     = 1'b0;
    doClear    = 1'b0;
    case (reqOp)
      opClear: doClear = 1'b1;
      opAlloc: begin
        errorCode = allocAvailable ? errNone : errOutOfMemory;
        doAlloc   = 1'b1;
        result    = dataBits'(allocArray);
      end
      opFree: begin
        errorCode = arrayError;                   // Double free lands on errFreed
        doFree    = 1'b1;
      end
      opWrite: begin
        errorCode  = arrayError;
        storeValue = 1'b1;
        result     = reqData;
        if (!inBounds) begin
          changeSize = 1'b1;                      // Grow to cover the index
          newSize    = {1'b0, reqIndex} + 1'b1;
        end
      end
      opRead: begin
        errorCode = checkOp(arrayError, !inBounds, errOutOfBounds);
        result    = readData;
      end
      opSize: begin
        errorCode = arrayError;
        result    = dataBits'(arraySize);
      end
      opPush: begin
        errorCode  = checkOp(arrayError, arraySize == sizeBits'(depth), errFull);
        storeValue = 1'b1;
        changeSize = 1'b1;
        newSize    = grownSize;
        result     = reqData;
      end
      opPop: begin
        errorCode  = checkOp(arrayError, arraySize == '0, errEmpty);
        changeSize = 1'b1;
        newSize    = lastSize;
        result     = readData;
      end
      opAdd, opAddAfter, opSub, opSubAfter, opShiftLeft, opShiftRight,
      opNot, opOr, opXor, opAnd: begin
        errorCode  = checkOp(arrayError, !inBounds, errOutOfBounds);
        storeValue = 1'b1;
        result     = (reqOp == opAddAfter || reqOp == opSubAfter) ? readData : aluValue;
      end
      default: result = '0;                       // Unused opcodes do nothing
    endcase
  end

  // Commit only a legal request
  assign commit      = reqValid && (errorCode == errNone);
  assign writeStrobe = commit && storeValue;
  assign writeIndex  = elementIndex;
  assign writeData   = aluValue;
  assign sizeWrite   = commit && changeSize;
  assign sizeValue   = newSize;
  assign allocStrobe = commit && doAlloc;
  assign freeStrobe  = commit && doFree;
  assign clearStrobe = commit && doClear;

  //----------------------------
  // Response register
  //----------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
      respData  <= '0;
      respError <= errNone;
    end else begin
      respValid <= reqValid;
      if (reqValid) begin
        respData  <= (errorCode == errNone) ? result : '0;
        respError <= errorCode;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/heapPkg.sv
`default_nettype none
//----------------------------
// Array heap package
// Opcodes, error codes and the width helpers used by the heap blocks
//----------------------------

package heapPkg;

  //----------------------------
  // Request opcodes
  //----------------------------
  typedef enum logic [4:0] {
    opClear      = 5'd0,   // Drop every array
    opAlloc      = 5'd1,   // Hand out a new array
    opFree       = 5'd2,   // Give an array back
    opWrite      = 5'd3,   // Store an element, growing the size
    opRead       = 5'd4,   // Fetch an element
    opSize       = 5'd5,   // Current array size
    opPush       = 5'd6,   // Append at the end
    opPop        = 5'd7,   // Remove from the end
    opAdd        = 5'd8,   // New value returned
    opAddAfter   = 5'd9,   // Old value returned
    opSub        = 5'd10,
    opSubAfter   = 5'd11,
    opShiftLeft  = 5'd12,
    opShiftRight = 5'd13,
    opNot        = 5'd14,  // Bitwise
    opOr         = 5'd15,
    opXor        = 5'd16,
    opAnd        = 5'd17
  } heapOp_e;

  //----------------------------
  // Response error codes
  //----------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,  // Array number never handed out
    errFreed        = 3'd2,  // Array was given back
    errOutOfBounds  = 3'd3,  // Index at or past the size
    errFull         = 3'd4,  // Push with no room left
    errEmpty        = 3'd5,  // Pop with nothing stored
    errOutOfMemory  = 3'd6   // No block left to allocate
  } heapErr_e;

  // Entries addressed by a field of the given width
  function automatic int depthOf(input int bits);
    return 1 << bits;
  endfunction

  // A size counts up to the full depth, so one extra bit
  function automatic int sizeWidth(input int indexBits);
    return indexBits + 1;
  endfunction

endpackage

`default_nettype wire

// File: vlog.f
verilog/heapPkg.sv
verilog/arrayDirectory.sv
verilog/elementStore.sv
verilog/heapController.sv
verilog/arrayHeap.sv
testbench/clockGen.sv
testbench/arrayHeap_assert.sv
testbench/arrayHeapTb.sv
